// ==== Bender.yml ====
package:
  name: word_merge

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/merge_pkg.sv
      - src/word_fifo.sv
      - src/priority_merge.sv
      - src/word_merge_top.sv

  - target: test
    include_dirs:
      - src
      - dv
    files:
      - dv/merge_tb.sv

// ==== dv/merge_tb_table.svh ====
// **********************************************************
// Stimulus table of the merger testbench, one row per test.
// Included inside the testbench module, filled by fill_table.
// **********************************************************

`ifndef MERGE_TB_TABLE_SVH
`define MERGE_TB_TABLE_SVH

// columns: name, port 0 count and words, port 1 count and words,
//          word source (0 listed, 1 LFSR), out_ready mode, latency, expected outputs
// out_ready mode 0 always high, 1 low until both ingress FIFOs fill, 2 LFSR gaps
// listed words go first to last from left to right, latency 0 is not checked

localparam int num_rows  = 6;
localparam int max_words = 12; // per port and row

typedef logic [max_words*`MERGE_WORD_W-1:0] word_list_t;

string      row_name [num_rows];
int         row_n0   [num_rows]; // words sent on port 0
word_list_t row_w0   [num_rows];
int         row_n1   [num_rows]; // words sent on port 1
word_list_t row_w1   [num_rows];
int         row_src  [num_rows]; // listed or random words
int         row_mode [num_rows]; // out_ready pattern
int         row_lat  [num_rows]; // cycles, acceptance to out_valid
int         row_exp  [num_rows]; // words expected at the output

task automatic set_row(input int r, input string name, input int n0, input word_list_t w0,
                       input int n1, input word_list_t w1, input int src, input int mode,
                       input int lat, input int exp_n);
    row_name[r] = name;
    row_n0[r]   = n0;
    row_w0[r]   = w0;
    row_n1[r]   = n1;
    row_w1[r]   = w1;
    row_src[r]  = src;
    row_mode[r] = mode;
    row_lat[r]  = lat;
    row_exp[r]  = exp_n;
endtask

task automatic fill_table();
    set_row(0, "single_latency", 0, '0, 1, {10'h2a5}, 0, 0, 2, 1);
    set_row(1, "null_drop_order",
            6, {10'h011, 10'h000, 10'h022, 10'h033, 10'h000, 10'h044},
            5, {10'h000, 10'h101, 10'h000, 10'h202, 10'h303}, 0, 0, 0, 7);
    set_row(2, "mostly_null",
            4, {10'h000, 10'h000, 10'h000, 10'h000},
            3, {10'h3ff, 10'h000, 10'h155}, 0, 0, 0, 2);
    set_row(3, "priority_fill", 12, '0, 8, '0, 1, 1, 0, 20); // 4 out + 8 in on port 0
    set_row(4, "random_backpressure", 12, '0, 12, '0, 1, 2, 0, 24);
    set_row(5, "random_uneven", 5, '0, 11, '0, 1, 2, 0, 16);
endtask

`endif // MERGE_TB_TABLE_SVH

// ==== dv/merge_tb.sv ====
// **********************************************************
// Testbench of the two-port word merger. Applies the stimulus
// table row by row and scoreboards the tagged output stream.
// **********************************************************

`timescale 1ns/1ps
`default_nettype none

`include "merge_settings.svh"

module merge_tb import merge_pkg::*; ();

`include "merge_tb_table.svh"

    localparam int wait_limit = 1000; // cycles per wait loop

    logic        clk;
    logic        reset;
    word_t       in_word_0;
    logic        in_valid_0;
    logic        in_ready_0;
    word_t       in_word_1;
    logic        in_valid_1;
    logic        in_ready_1;
    word_t       out_word;
    src_t        out_src;
    logic        out_valid;
    logic        out_ready;

    word_t       exp_q0 [$];       // port 0 words still due, nulls skipped
    word_t       exp_q1 [$];
    word_t       stim0 [max_words]; // words of the current row
    word_t       stim1 [max_words];
    logic [15:0] lfsr;
    int          cycle;             // rising edges so far
    int          accept_cycle;      // edge of the last accepted word
    int          value_errors;
    int          other_errors;
    logic        row_done;          // output side finished the row

    word_merge_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .in_word_0  (in_word_0),
        .in_valid_0 (in_valid_0),
        .in_ready_0 (in_ready_0),
        .in_word_1  (in_word_1),
        .in_valid_1 (in_valid_1),
        .in_ready_1 (in_ready_1),
        .out_word   (out_word),
        .out_src    (out_src),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    always #5 clk = ~clk; // 10 ns period

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic next_bit();
        logic b;
        b    = lfsr[0];
        lfsr = {1'b0, lfsr[15:1]} ^ (b ? 16'hb400 : 16'h0000);
        return b;
    endfunction

    // nonzero random word, redrawn on all zeros
    function automatic word_t random_word();
        word_t w;
        int    i;
        w = '0;
        while (w == '0)
        begin
            for (i = 0; i < `MERGE_WORD_W; i++)
            begin
                w = {w[`MERGE_WORD_W-2:0], next_bit()};
            end
        end
        return w;
    endfunction

    // i-th listed word, leftmost first
    function automatic word_t list_word(input word_list_t l, input int n, input int i);
        return l[(n-1-i)*`MERGE_WORD_W +: `MERGE_WORD_W];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            value_errors++;
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        other_errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // push one port's words, holding each until in_ready takes it
    task automatic drive_port(input int port, input int n);
        int    i;
        int    waited;
        logic  ready;
        logic  stuck;
        word_t w;
        stuck = 1'b0;
        for (i = 0; i < n && !stuck; i++)
        begin
            w = (port == 0) ? stim0[i] : stim1[i];
            if (port == 0)
            begin
                in_word_0  <= w;
                in_valid_0 <= 1'b1;
            end
            else
            begin
                in_word_1  <= w;
                in_valid_1 <= 1'b1;
            end
            waited = 0;
            @(posedge clk);
            ready = (port == 0) ? in_ready_0 : in_ready_1;
            while (!ready && waited < wait_limit)
            begin
                @(posedge clk);
                waited++;
                ready = (port == 0) ? in_ready_0 : in_ready_1;
            end
            if (!ready)
            begin
                report_failure($sformatf("port %0d word %0d was never accepted", port, i));
                stuck = 1'b1;
            end
            else
            begin
                accept_cycle = cycle; // transfer on this edge
                if (w != '0 && port == 0)
                    exp_q0.push_back(w);
                else if (w != '0)
                    exp_q1.push_back(w);
            end
        end
        if (port == 0)
            in_valid_0 <= 1'b0;
        else
            in_valid_1 <= 1'b0;
    endtask

    task automatic drive_ready(input int mode);
        int waited;
        waited = 0;
        if (mode == 0)
        begin
            out_ready <= 1'b1;
        end
        else if (mode == 1)
        begin
            out_ready <= 1'b0; // stall until both sides back up
            @(posedge clk);
            while ((in_ready_0 || in_ready_1) && waited < wait_limit)
            begin
                @(posedge clk);
                waited++;
            end
            if (in_ready_0 || in_ready_1)
                report_failure("ingress FIFOs did not fill while out_ready was low");
            out_ready <= 1'b1;
        end
        else
        begin
            while (!row_done && waited < 4 * wait_limit)
            begin
                out_ready <= next_bit(); // about half the cycles
                @(posedge clk);
                waited++;
            end
            if (!row_done)
                report_failure("output did not drain under random out_ready");
            out_ready <= 1'b1;
        end
    endtask

    // scoreboard, one expected queue per source
    task automatic watch_output(input int r, input int want);
        int    got;
        int    waited;
        int    first_cycle;
        int    i;
        logic  seen_src1;
        word_t exp_word;
        got         = 0;
        waited      = 0;
        first_cycle = -1;
        seen_src1   = 1'b0;
        while (got < want && waited < wait_limit)
        begin
            @(posedge clk);
            waited++;
            if (out_valid && first_cycle < 0)
                first_cycle = cycle;
            if (out_valid && out_ready)
            begin
                got++;
                waited = 0; // progress restarts the timeout
                if (out_src == 1'b0 && seen_src1 && row_mode[r] == 1)
                    report_failure({row_name[r], ": port 0 word came after a port 1 word"});
                if (out_src == 1'b1)
                    seen_src1 = 1'b1;
                if ((out_src == 1'b0 && exp_q0.size() == 0) ||
                    (out_src == 1'b1 && exp_q1.size() == 0))
                begin
                    report_failure($sformatf("%s: word %0h from port %0d was never sent",
                                             row_name[r], out_word, out_src));
                end
                else
                begin
                    if (out_src == 1'b0)
                        exp_word = exp_q0.pop_front();
                    else
                        exp_word = exp_q1.pop_front();
                    check_value({row_name[r], " word"}, exp_word, out_word);
                end
            end
        end
        if (got < want)
            report_failure({row_name[r], ": timed out waiting for output words"});
        row_done <= 1'b1;
        check_value({row_name[r], " count"}, row_exp[r], got);
        if (row_lat[r] != 0)
            check_value({row_name[r], " latency"}, row_lat[r], first_cycle - accept_cycle);
        for (i = 0; i < 4; i++)
        begin
            @(posedge clk);
            if (out_valid)
                report_failure({row_name[r], ": extra word on the output"});
        end
        if (exp_q0.size() != 0 || exp_q1.size() != 0)
            report_failure({row_name[r], ": expected words never came out"});
        exp_q0.delete();
        exp_q1.delete();
    endtask

    initial
    begin : run_tests
        int r;
        int i;
        int want;
        clk          = 1'b0;
        reset        = 1'b0;
        in_word_0    = '0;
        in_valid_0   = 1'b0;
        in_word_1    = '0;
        in_valid_1   = 1'b0;
        out_ready    = 1'b0;
        lfsr         = 16'd97;
        cycle        = 0;
        accept_cycle = 0;
        value_errors = 0;
        other_errors = 0;
        row_done     = 1'b0;
        fill_table();

        repeat (10) @(posedge clk);
        reset <= 1'b1;
        @(posedge clk); // first cycle out of reset
        check_value("reset in_ready_0", 1, in_ready_0);
        check_value("reset in_ready_1", 1, in_ready_1);
        check_value("reset out_valid", 0, out_valid);

        for (r = 0; r < num_rows; r++)
        begin
            want = 0;
            for (i = 0; i < max_words; i++)
            begin
                stim0[i] = '0;
                stim1[i] = '0;
                if (i < row_n0[r])
                    stim0[i] = row_src[r] ? random_word() : list_word(row_w0[r], row_n0[r], i);
                if (i < row_n1[r])
                    stim1[i] = row_src[r] ? random_word() : list_word(row_w1[r], row_n1[r], i);
                if (stim0[i] != '0)
                    want++;
                if (stim1[i] != '0)
                    want++;
            end
            row_done <= 1'b0;
            @(posedge clk);
            fork
                drive_port(0, row_n0[r]);
                drive_port(1, row_n1[r]);
                drive_ready(row_mode[r]);
                watch_output(r, want);
            join
            repeat (2) @(posedge clk);
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule : merge_tb

`default_nettype wire

// ==== sources.f ====
+incdir+src
+incdir+dv
src/merge_pkg.sv
src/word_fifo.sv
src/priority_merge.sv
src/word_merge_top.sv
dv/merge_tb.sv

// ==== src/merge_pkg.sv ====
// **********************************************************
// Shared types of the word merger: data word, source id and
// the tagged word written into the output FIFO.
// **********************************************************

`default_nettype none

package merge_pkg;

`include "merge_settings.svh"

    // plain data word as pushed by an ingress port
    typedef logic [`MERGE_WORD_W-1:0] word_t;

    // ingress port number, 0 has priority
    typedef logic [`MERGE_SRC_W-1:0] src_t;

    // word plus its source tag, src in the top bit
    typedef struct packed {
        src_t  src;  // port the word came from
        word_t word; // never zero once tagged
    } tagged_t;

    // an all-zero word carries no data
    function automatic logic is_null_word(input word_t w);
        return (w == '0);
    endfunction

endpackage : merge_pkg

`default_nettype wire

// ==== src/merge_settings.svh ====
// **********************************************************
// Word width and FIFO depths of the two-port word merger.
// Included by the package and by the top level.
// **********************************************************

`ifndef MERGE_SETTINGS_SVH
`define MERGE_SETTINGS_SVH

// payload width of one data word, all zeros is the null word
`define MERGE_WORD_W 10

// one bit is enough for two ingress ports
`define MERGE_SRC_W 1

// ingress FIFO depth, power of two
`define MERGE_IN_DEPTH 8

// output FIFO depth, power of two
`define MERGE_OUT_DEPTH 4

`endif // MERGE_SETTINGS_SVH

// ==== src/priority_merge.sv ====
// **********************************************************
// Strict-priority merge of two ingress FIFO heads. Port 0 wins
// whenever it has a word; null words are popped and dropped.
// **********************************************************

`timescale 1ns/1ps
`default_nettype none

module priority_merge import merge_pkg::*; (
    input  logic    clk,          // assertion clock only
    input  logic    reset,        // synchronous active low
    input  word_t   head_word_0,  // ingress FIFO 0 head
    input  logic    head_valid_0, // FIFO 0 not empty
    output logic    pop_0,        // ready of FIFO 0
    input  word_t   head_word_1,  // ingress FIFO 1 head
    input  logic    head_valid_1, // FIFO 1 not empty
    output logic    pop_1,        // ready of FIFO 1
    output tagged_t merged,       // word to the output FIFO
    output logic    merged_valid,
    input  logic    merged_ready  // output FIFO not full
);

    src_t  sel_src;   // port currently granted
    word_t sel_word;  // its head word
    logic  sel_valid; // granted port has a word
    logic  sel_null;  // granted word is all zeros
    logic  take;      // pop the granted head this cycle

    // port 1 is granted only when port 0 is empty
    always_comb
    begin
        if (head_valid_0)
        begin
            sel_src   = src_t'(0);
            sel_word  = head_word_0;
            sel_valid = 1'b1;
        end
        else
        begin
            sel_src   = src_t'(1);
            sel_word  = head_word_1;
            sel_valid = head_valid_1; // may be idle
        end
    end

    assign sel_null = is_null_word(sel_word);

    // nulls never reach the output
    always_comb
    begin
        merged.src   = sel_src;
        merged.word  = sel_word;
        merged_valid = sel_valid & ~sel_null; // no ready in here
    end

    // null words need no room but real ones wait for space
    assign take = sel_valid & (sel_null | merged_ready);

    // at most one pop per cycle to the granted port
    always_comb
    begin
        pop_0 = 1'b0;
        pop_1 = 1'b0;
        if (take)
        begin
            if (sel_src == src_t'(0))
            begin
                pop_0 = 1'b1;
            end
            else
            begin
                pop_1 = 1'b1; // port 0 was empty
            end
        end
    end

    // one FIFO popped per cycle
    a_one_pop : assert property (
        @(posedge clk) disable iff (!reset)
        !(pop_0 && pop_1)
    ) else $error("priority_merge: both ports popped");

    // port 1 waits while port 0 holds a word
    a_port1_yields : assert property (
        @(posedge clk) disable iff (!reset)
        head_valid_0 |-> !pop_1
    ) else $error("priority_merge: port 1 popped over port 0");

    // the output stream carries data only
    a_no_null_out : assert property (
        @(posedge clk) disable iff (!reset)
        merged_valid |-> (merged.word != '0)
    ) else $error("priority_merge: null word forwarded");

endmodule : priority_merge

`default_nettype wire

// ==== src/word_fifo.sv ====
// **********************************************************
// Synchronous FIFO with valid/ready on both sides and a type
// parameter for the payload. The head is read from storage with no fall-through.
// **********************************************************

`timescale 1ns/1ps
`default_nettype none

module word_fifo #(
    parameter type payload_t = logic [7:0], // stored item
    parameter int  depth     = 4            // entries as a power of two
) (
    input  logic     clk,
    input  logic     reset,      // synchronous active low
    input  payload_t push_data,  // write side
    input  logic     push_valid,
    output logic     push_ready, // low only when full
    output payload_t pop_data,   // head of the queue
    output logic     pop_valid,  // high when not empty
    input  logic     pop_ready
);

    localparam int addr_w = $clog2(depth); // entry index bits
    localparam int ptr_w  = addr_w + 1;    // extra wrap bit

    // depth must split cleanly into index and wrap bit
    if (depth < 2 || (depth & (depth - 1)) != 0)
    begin : g_bad_depth
        $error("word_fifo depth must be a power of two, at least 2");
    end

    payload_t         mem [depth]; // circular storage
    logic [ptr_w-1:0] wr_ptr;      // next slot to write
    logic [ptr_w-1:0] rd_ptr;      // slot of the head
    logic             full;
    logic             empty;
    logic             do_push;     // accepted write this edge
    logic             do_pop;      // accepted read this edge

    // same index on a different lap means full
    assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                   (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);
    assign empty = (wr_ptr == rd_ptr); // same lap too

    assign push_ready = ~full;         // independent of pop side
    assign pop_valid  = ~empty;
    assign pop_data   = mem[rd_ptr[addr_w-1:0]];

    assign do_push = push_valid & push_ready;
    assign do_pop  = pop_valid & pop_ready;

    // storage written on accepted push
    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr[addr_w-1:0]] <= push_data;
        end
    end

    // write pointer
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            wr_ptr <= '0; // empty after reset
        end
        else if (do_push)
        begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // read pointer
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            rd_ptr <= '0;
        end
        else if (do_pop)
        begin
            rd_ptr <= rd_ptr + 1'b1; // next entry becomes head
        end
    end

    // a push offered while full leaves the write pointer alone
    a_no_push_when_full : assert property (
        @(posedge clk) disable iff (!reset)
        (push_valid && full) |=> (wr_ptr == $past(wr_ptr))
    ) else $error("word_fifo: push accepted while full");

    // a pop offered while empty leaves the read pointer alone
    a_no_pop_when_empty : assert property (
        @(posedge clk) disable iff (!reset)
        (pop_ready && empty) |=> (rd_ptr == $past(rd_ptr))
    ) else $error("word_fifo: pop accepted while empty");

endmodule : word_fifo

`default_nettype wire

// ==== src/word_merge_top.sv ====
// **********************************************************
// Two-port word merger. Two ingress FIFOs feed a strict-priority
// merge stage, whose tagged words leave through an output FIFO.
// **********************************************************

`timescale 1ns/1ps
`default_nettype none

`include "merge_settings.svh"

module word_merge_top import merge_pkg::*; (
    input  logic  clk,
    input  logic  reset,      // sync, active low
    input  word_t in_word_0,  // port 0 ingress
    input  logic  in_valid_0,
    output logic  in_ready_0,
    input  word_t in_word_1,  // port 1 ingress
    input  logic  in_valid_1,
    output logic  in_ready_1,
    output word_t out_word,   // merged stream
    output src_t  out_src,    // port the word came from
    output logic  out_valid,
    input  logic  out_ready
);

    word_t   head_word_0;  // ingress FIFO heads
    logic    head_valid_0;
    logic    pop_0;
    word_t   head_word_1;
    logic    head_valid_1;
    logic    pop_1;
    tagged_t push_word;    // merge to output FIFO
    logic    push_valid;
    logic    push_ready;
    tagged_t out_head;     // output FIFO head

    // port 0 ingress, the high priority side
    word_fifo #(
        .payload_t (word_t),
        .depth     (`MERGE_IN_DEPTH)
    ) in_fifo_0 (
        .clk        (clk),
        .reset      (reset),
        .push_data  (in_word_0),
        .push_valid (in_valid_0),
        .push_ready (in_ready_0),
        .pop_data   (head_word_0),
        .pop_valid  (head_valid_0),
        .pop_ready  (pop_0)
    );

    // port 1 ingress, served when port 0 is empty
    word_fifo #(
        .payload_t (word_t),
        .depth     (`MERGE_IN_DEPTH)
    ) in_fifo_1 (
        .clk        (clk),
        .reset      (reset),
        .push_data  (in_word_1),
        .push_valid (in_valid_1),
        .push_ready (in_ready_1),
        .pop_data   (head_word_1),
        .pop_valid  (head_valid_1),
        .pop_ready  (pop_1)
    );

    priority_merge merge0 (
        .clk          (clk),
        .reset        (reset),
        .head_word_0  (head_word_0),
        .head_valid_0 (head_valid_0),
        .pop_0        (pop_0),
        .head_word_1  (head_word_1),
        .head_valid_1 (head_valid_1),
        .pop_1        (pop_1),
        .merged       (push_word),
        .merged_valid (push_valid),
        .merged_ready (push_ready)
    );

    // tagged words queue here under back-pressure
    word_fifo #(
        .payload_t (tagged_t),
        .depth     (`MERGE_OUT_DEPTH)
    ) out_fifo0 (
        .clk        (clk),
        .reset      (reset),
        .push_data  (push_word),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .pop_data   (out_head),
        .pop_valid  (out_valid),
        .pop_ready  (out_ready)
    );

    assign out_word = out_head.word; // split the tag off
    assign out_src  = out_head.src;

endmodule : word_merge_top

`default_nettype wire
